// ==== fpga_qla_top.f ====
+incdir+src
src/qla_reg_pkg.sv
src/qla_axis_pkg.sv
src/reg_bus_if.sv
src/board_regs.sv
src/dac_cmd_regs.sv
src/safety_check.sv
src/fpga_qla_top.sv
tests/fpga_qla_properties.sv
tests/fpga_qla_tb.sv

// ==== Makefile ====
# Verilator build and run for the motor-axis core testbench

VERILATOR ?= verilator
TOP       ?= fpga_qla_tb
FILELIST  ?= fpga_qla_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert
PASS_MSG  ?= >>> PASS

SRCS := $(wildcard src/*.sv src/*.svh tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the run prints the pass line
sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/fpga_qla_tb.sv ====
// --------------------------------------------------
// testbench for the motor-axis core: register bus,
// enables, digital outputs and the safety trip
// --------------------------------------------------
`timescale 1ns/1ps
`include "qla_params.svh"

module fpga_qla_tb;

    import qla_reg_pkg::*;
    import qla_axis_pkg::*;

    localparam int TRIP_AXIS = 1;                          // axis 2, channel 2
    // reset, then reset state, dac, status, dout, safety, unmapped
    localparam int TEST_CYCLES = 10 + 20 + 80 + 60 + 60 + 60 + 30;

    logic                         sysclk;
    logic                         reset;
    reg_addr_t                    reg_raddr;
    reg_addr_t                    reg_waddr;
    reg_data_t                    reg_wdata;
    logic                         reg_wen;
    logic [`QLA_BOARD_ID_W-1:0]   board_id;
    logic                         dout_bidir;
    current_t [`QLA_NUM_AXES-1:0] cur_fb;
    reg_data_t                    reg_rdata;
    logic                         pwr_enable;
    axis_mask_t                   amp_enable;
    logic [3:0]                   dout_pins;

    logic        rd_valid;                 // read word due after this edge
    reg_data_t   exp_q[$];                 // expected read words, oldest first
    string       name_q[$];
    int          reads_issued = 0;
    int          reads_done = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    int          errors_at_start = 0;
    string       test_name;
    logic [31:0] rng_state = 32'hc236;

    fpga_qla_top u_fpga_qla_top (.*);

    bind fpga_qla_top fpga_qla_properties u_fpga_qla_properties (
        .sysclk, .reset, .pwr_enable, .amp_enable, .safety_disable, .clear_disable, .reg_rdata
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);     // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic reg_addr_t make_addr(addr_space_e sp, logic [3:0] chan, reg_offset_e off);
        return {sp, 4'h0, chan, off};
    endfunction

    function automatic reg_data_t status_write_word(logic pwr, axis_mask_t req);
        return {12'h000, pwr, 15'h0000, req};          // pwr in bit 19
    endfunction

    function automatic reg_data_t exp_status(logic [3:0] id, logic pwr, logic bidir,
                                             axis_mask_t dis, axis_mask_t req);
        reg_data_t r;
        r        = '0;
        r[27:24] = id;
        r[19]    = pwr;
        r[18]    = bidir;
        r[11:8]  = dis;
        r[3:0]   = req;
        return r;
    endfunction

    function automatic reg_data_t exp_dac_readback(current_t value);
        return {16'h0000, value};                      // zero extended
    endfunction

    function automatic logic [3:0] exp_pins(logic [3:0] dout, logic bidir);
        return bidir ? ~dout : dout;
    endfunction

    // |fb| > 2*|cmd| + margin, magnitudes about midscale
    function automatic bit over_limit(current_t fb, current_t cmd);
        int mid;
        int fb_mag;
        int cmd_mag;
        mid     = int'(`QLA_CUR_MIDSCALE);
        fb_mag  = (int'(fb) >= mid) ? int'(fb) - mid : mid - int'(fb);
        cmd_mag = (int'(cmd) >= mid) ? int'(cmd) - mid : mid - int'(cmd);
        return fb_mag > 2 * cmd_mag + int'(`QLA_SAFETY_MARGIN);
    endfunction

    // --------------------------------------------------
    // compare tasks and bus access
    // --------------------------------------------------
    task automatic check_data(input string name, input reg_data_t expected, input reg_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s / %s: expected %h, actual %h",
                     test_name, name, expected, actual);
        end
    endtask

    task automatic check_mask(input string name, input axis_mask_t expected,
                              input axis_mask_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s / %s: expected %b, actual %b",
                     test_name, name, expected, actual);
        end
    endtask

    task automatic check_pins(input string name, input logic [3:0] expected,
                              input logic [3:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s / %s: expected %b, actual %b",
                     test_name, name, expected, actual);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);                             // write lands here
        reg_wen   <= 1'b0;
    endtask

    // queue the expectation, wait for the compare process
    task automatic read_expect(input string name, input reg_addr_t addr, input reg_data_t expected);
        @(posedge sysclk);
        reg_raddr <= addr;
        rd_valid  <= 1'b1;
        exp_q.push_back(expected);
        name_q.push_back(name);
        reads_issued++;
        @(posedge sysclk);
        rd_valid  <= 1'b0;
        reg_raddr <= '1;                               // park on an unmapped space
        wait (reads_done == reads_issued);
    endtask

    initial begin : read_compare
        reg_data_t expected;
        string     name;
        forever begin
            @(posedge sysclk);
            if (rd_valid) begin
                @(negedge sysclk);                     // rdata settled one cycle on
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                check_data(name, expected, reg_rdata);
                reads_done++;
            end
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        test_count++;
        if (error_count != errors_at_start) begin
            failed_tests++;
            $display("test %-16s FAILED, %0d errors", test_name, error_count - errors_at_start);
        end else begin
            $display("test %-16s ok", test_name);
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic reset_state();
        start_test("reset state");
        @(negedge sysclk);
        check_mask("amp_enable", '0, amp_enable);
        check_data("pwr_enable", '0, reg_data_t'(pwr_enable));
        check_pins("dout_pins", exp_pins(4'h0, dout_bidir), dout_pins);
        read_expect("status", make_addr(SPACE_MAIN, 4'd0, OFF_STATUS),
                    exp_status(board_id, 1'b0, dout_bidir, '0, '0));
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            read_expect($sformatf("dac ch%0d", i + 1),
                        make_addr(SPACE_MAIN, 4'(i + 1), OFF_DAC_CTRL), '0);
        end
        finish_test();
    endtask

    task automatic dac_commands();
        current_t cmd [`QLA_NUM_AXES];
        current_t fb [`QLA_NUM_AXES];
        start_test("dac commands");
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                cmd[i] = current_t'(next_random());
                write_reg(make_addr(SPACE_MAIN, 4'(i + 1), OFF_DAC_CTRL),
                          {16'(next_random()), cmd[i]});    // upper half ignored
            end
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                read_expect($sformatf("dac ch%0d cmd", i + 1),
                            make_addr(SPACE_MAIN, 4'(i + 1), OFF_DAC_CTRL),
                            exp_dac_readback(cmd[i]));
            end
            @(posedge sysclk);
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                fb[i] = current_t'(next_random());
                cur_fb[i] <= fb[i];
            end
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                read_expect($sformatf("adc ch%0d fb", i + 1),
                            make_addr(SPACE_MAIN, 4'(i + 1), OFF_ADC_DATA),
                            exp_dac_readback(fb[i]));
            end
        end
        // random feedback may have tripped axes, power on clears them all
        @(posedge sysclk);
        cur_fb <= {`QLA_NUM_AXES{`QLA_CUR_MIDSCALE}};
        write_reg(make_addr(SPACE_MAIN, 4'd0, OFF_STATUS), status_write_word(1'b1, '0));
        write_reg(make_addr(SPACE_MAIN, 4'd0, OFF_STATUS), status_write_word(1'b0, '0));
        finish_test();
    endtask

    task automatic status_enables();
        logic       pwr;
        axis_mask_t req;
        start_test("status enables");
        for (int n = 0; n < 8; n++) begin
            pwr = 1'(next_random());
            req = axis_mask_t'(next_random());
            @(posedge sysclk);
            board_id <= 4'(next_random());
            write_reg(make_addr(SPACE_MAIN, 4'd0, OFF_STATUS), status_write_word(pwr, req));
            @(negedge sysclk);
            check_mask($sformatf("amp_enable #%0d", n), pwr ? req : '0, amp_enable);
            read_expect($sformatf("status #%0d", n), make_addr(SPACE_MAIN, 4'd0, OFF_STATUS),
                        exp_status(board_id, pwr, dout_bidir, '0, req));
        end
        finish_test();
    endtask

    task automatic digital_outputs();
        logic [3:0] d;
        start_test("digital outputs");
        for (int b = 0; b < 2; b++) begin
            @(posedge sysclk);
            dout_bidir <= 1'(b);
            for (int n = 0; n < 4; n++) begin
                d = 4'(next_random());
                write_reg(make_addr(SPACE_MAIN, 4'd0, OFF_DOUT_CTRL), {28'(next_random()), d});
                @(negedge sysclk);
                check_pins($sformatf("pins bidir %0d #%0d", b, n), exp_pins(d, 1'(b)), dout_pins);
                read_expect($sformatf("dout read #%0d", n),
                            make_addr(SPACE_MAIN, 4'd0, OFF_DOUT_CTRL), {28'h0, d});
            end
        end
        finish_test();
    endtask

    task automatic safety_trip();
        current_t   cmd;
        current_t   fb_over;
        current_t   fb_ok;
        axis_mask_t after_trip;
        reg_addr_t  status_addr;
        start_test("safety trip");
        cmd         = `QLA_CUR_MIDSCALE + 16'h0200;         // |cmd| 0x200, limit 0x500
        fb_over     = `QLA_CUR_MIDSCALE + 16'h0600;
        fb_ok       = `QLA_CUR_MIDSCALE - 16'h0100;         // negative, well inside
        after_trip  = over_limit(fb_over, cmd) ? ~axis_mask_t'(1 << TRIP_AXIS) : '1;
        status_addr = make_addr(SPACE_MAIN, 4'd0, OFF_STATUS);
        write_reg(make_addr(SPACE_MAIN, 4'(TRIP_AXIS + 1), OFF_DAC_CTRL), {16'h0000, cmd});
        write_reg(status_addr, status_write_word(1'b1, '1));
        // one edge short of the trip count
        @(posedge sysclk);
        cur_fb[TRIP_AXIS] <= fb_over;
        repeat (`QLA_SAFETY_TRIP_COUNT - 1) @(posedge sysclk);
        cur_fb[TRIP_AXIS] <= fb_ok;
        @(negedge sysclk);
        check_mask("short hold", '1, amp_enable);
        @(negedge sysclk);
        check_mask("after short hold", '1, amp_enable);
        // full count latches
        @(posedge sysclk);
        cur_fb[TRIP_AXIS] <= fb_over;
        repeat (`QLA_SAFETY_TRIP_COUNT) @(posedge sysclk);
        cur_fb[TRIP_AXIS] <= fb_ok;
        @(negedge sysclk);
        check_mask("full hold", after_trip, amp_enable);
        read_expect("tripped status", status_addr,
                    exp_status(board_id, 1'b1, dout_bidir, ~after_trip, '1));
        // enable write re-arms, state back one edge later
        write_reg(status_addr, status_write_word(1'b1, '1));
        @(negedge sysclk);
        @(negedge sysclk);
        check_mask("re-enabled", '1, amp_enable);
        read_expect("cleared status", status_addr,
                    exp_status(board_id, 1'b1, dout_bidir, '0, '1));
        finish_test();
    endtask

    task automatic unmapped_spaces();
        addr_space_e spaces [4];
        spaces = '{SPACE_HUB, SPACE_PROM, SPACE_PROM_QLA, SPACE_DS};
        start_test("unmapped spaces");
        for (int s = 0; s < 4; s++) begin
            read_expect($sformatf("%s status", spaces[s].name()),
                        make_addr(spaces[s], 4'd0, OFF_STATUS), '0);
            read_expect($sformatf("%s dac", spaces[s].name()),
                        make_addr(spaces[s], 4'(TRIP_AXIS + 1), OFF_DAC_CTRL), '0);
        end
        finish_test();
    endtask

    // --------------------------------------------------
    // run
    // --------------------------------------------------
    initial begin : stimulus
        reset      <= 1'b1;
        reg_raddr  <= '0;
        reg_waddr  <= '0;
        reg_wdata  <= '0;
        reg_wen    <= 1'b0;
        rd_valid   <= 1'b0;
        board_id   <= 4'h5;
        dout_bidir <= 1'b1;                            // pins idle high
        cur_fb     <= {`QLA_NUM_AXES{`QLA_CUR_MIDSCALE}};
        repeat (5) @(posedge sysclk);
        reset <= 1'b0;
        reset_state();
        dac_commands();
        status_enables();
        digital_outputs();
        safety_trip();
        unmapped_spaces();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(TEST_CYCLES * 2 * 10);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES * 2);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tests/fpga_qla_properties.sv ====
// --------------------------------------------------
// bound checks: power gating, trip latching and
// the read register after reset
// --------------------------------------------------
`timescale 1ns/1ps

module fpga_qla_properties (
    input logic                     sysclk,
    input logic                     reset,
    input logic                     pwr_enable,
    input qla_axis_pkg::axis_mask_t amp_enable,
    input qla_axis_pkg::axis_mask_t safety_disable,
    input qla_axis_pkg::axis_mask_t clear_disable,
    input qla_reg_pkg::reg_data_t   reg_rdata
);

    import qla_axis_pkg::*;

    axis_mask_t held;    // tripped, no clear pending

    assign held = safety_disable & ~clear_disable;

    // power off kills every amplifier
    a_amp_needs_power: assert property (@(posedge sysclk) disable iff (reset)
        !pwr_enable |-> amp_enable == '0)
        else $error("amp_enable active while pwr_enable is low");

    a_no_amp_when_tripped: assert property (@(posedge sysclk) disable iff (reset)
        (amp_enable & safety_disable) == '0)
        else $error("amp_enable active on a tripped axis");

    // trip stays until the host clears it
    a_trip_latched: assert property (@(posedge sysclk) disable iff (reset)
        held != '0 |=> (safety_disable & $past(held)) == $past(held))
        else $error("safety trip dropped without a clear");

    a_rdata_after_reset: assert property (@(posedge sysclk)
        reset |=> reg_rdata == '0)
        else $error("reg_rdata not zero after reset");

endmodule

// ==== src/fpga_qla_top.sv ====
// --------------------------------------------------
// motor-axis core top: host register bus, board and
// axis registers, safety check, registered read mux
// --------------------------------------------------
`timescale 1ns/1ps
`include "qla_params.svh"

module fpga_qla_top (
    input  logic                                       sysclk,
    input  logic                                       reset,
    input  qla_reg_pkg::reg_addr_t                     reg_raddr,
    input  qla_reg_pkg::reg_addr_t                     reg_waddr,
    input  qla_reg_pkg::reg_data_t                     reg_wdata,
    input  logic                                       reg_wen,
    input  logic [`QLA_BOARD_ID_W-1:0]                 board_id,     // rotary switch
    input  logic                                       dout_bidir,   // dout config level
    input  qla_axis_pkg::current_t [`QLA_NUM_AXES-1:0] cur_fb,       // sampled adc currents
    output qla_reg_pkg::reg_data_t                     reg_rdata,
    output logic                                       pwr_enable,
    output qla_axis_pkg::axis_mask_t                   amp_enable,
    output logic [3:0]                                 dout_pins
);

    import qla_reg_pkg::*;
    import qla_axis_pkg::*;

    // --------------------------------------------------
    // local wires between blocks
    // --------------------------------------------------
    current_t [`QLA_NUM_AXES-1:0] cur_cmd;        // dac commands to safety
    axis_mask_t                   clear_disable;  // enable write re-arms axis
    axis_mask_t                   safety_disable; // tripped axes
    reg_data_t                    board_rdata;    // channel 0 read word
    reg_data_t                    dac_rdata;      // channels 1..4 read word
    addr_space_e                  rspace;

    reg_bus_if bus ();

    // host side of the bus
    assign bus.waddr = reg_waddr;
    assign bus.wdata = reg_wdata;
    assign bus.wen   = reg_wen;
    assign bus.raddr = reg_raddr;

    board_regs u_board_regs (
        .sysclk         (sysclk),
        .reset          (reset),
        .bus            (bus),
        .board_id       (board_id),
        .dout_bidir     (dout_bidir),
        .safety_disable (safety_disable),
        .rdata          (board_rdata),
        .clear_disable  (clear_disable),
        .pwr_enable     (pwr_enable),
        .amp_enable     (amp_enable),
        .dout_pins      (dout_pins)
    );

    dac_cmd_regs u_dac_cmd_regs (
        .sysclk  (sysclk),
        .reset   (reset),
        .bus     (bus),
        .cur_fb  (cur_fb),
        .rdata   (dac_rdata),
        .cur_cmd (cur_cmd)
    );

    // trips when |fb| > 2*|cmd| + margin
    safety_check u_safety_check (
        .sysclk         (sysclk),
        .reset          (reset),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .clear_disable  (clear_disable),
        .safety_disable (safety_disable)
    );

    // --------------------------------------------------
    // read mux, one cycle latency
    // --------------------------------------------------
    assign rspace = addr_space_e'(reg_raddr[15:12]);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else begin
            case (rspace)
                SPACE_MAIN:
                    reg_rdata <= (reg_raddr[7:4] == 4'd0) ? board_rdata : dac_rdata;
                default:
                    reg_rdata <= '0;                      // blocks not on this board
            endcase
        end
    end

endmodule

// ==== src/safety_check.sv ====
// --------------------------------------------------
// per-axis overcurrent check: trips when feedback
// stays above twice the command, latched until clear
// --------------------------------------------------
`timescale 1ns/1ps
`include "qla_params.svh"

module safety_check (
    input  logic                                       sysclk,
    input  logic                                       reset,
    input  qla_axis_pkg::current_t [`QLA_NUM_AXES-1:0] cur_fb,
    input  qla_axis_pkg::current_t [`QLA_NUM_AXES-1:0] cur_cmd,
    input  qla_axis_pkg::axis_mask_t                   clear_disable,
    output qla_axis_pkg::axis_mask_t                   safety_disable
);

    import qla_axis_pkg::*;

    localparam int CNT_W = $clog2(`QLA_SAFETY_TRIP_COUNT) + 1;

    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        logic [15:0]      fb_mag;     // distance from midscale
        logic [15:0]      cmd_mag;
        logic [17:0]      limit;      // 2*cmd + margin, no overflow
        logic             over;
        logic [CNT_W-1:0] cnt;        // consecutive over-limit edges
        safe_state_e      state;

        assign fb_mag  = (cur_fb[i] >= `QLA_CUR_MIDSCALE) ? cur_fb[i] - `QLA_CUR_MIDSCALE
                                                          : `QLA_CUR_MIDSCALE - cur_fb[i];
        assign cmd_mag = (cur_cmd[i] >= `QLA_CUR_MIDSCALE) ? cur_cmd[i] - `QLA_CUR_MIDSCALE
                                                           : `QLA_CUR_MIDSCALE - cur_cmd[i];
        assign limit   = {1'b0, cmd_mag, 1'b0} + 18'(`QLA_SAFETY_MARGIN);
        assign over    = {2'b00, fb_mag} > limit;

        always_ff @(posedge sysclk) begin
            if (reset) begin
                state <= SAFE_ARMED;
                cnt   <= '0;
            end else begin
                case (state)
                    SAFE_ARMED: begin
                        if (over) begin
                            state <= SAFE_COUNTING;
                            cnt   <= CNT_W'(1);       // first over-limit edge
                        end
                    end
                    SAFE_COUNTING: begin
                        if (!over) begin
                            state <= SAFE_ARMED;      // glitch, start over
                            cnt   <= '0;
                        end else if (cnt == CNT_W'(`QLA_SAFETY_TRIP_COUNT - 1)) begin
                            state <= SAFE_TRIPPED;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    SAFE_TRIPPED: begin
                        // only a host enable write gets out of here
                        if (clear_disable[i]) begin
                            state <= SAFE_ARMED;
                            cnt   <= '0;
                        end
                    end
                    default: begin
                        state <= SAFE_ARMED;
                        cnt   <= '0;
                    end
                endcase
            end
        end

        assign safety_disable[i] = (state == SAFE_TRIPPED);
    end

endmodule

// ==== src/dac_cmd_regs.sv ====
// --------------------------------------------------
// per-axis current command registers, with command
// and feedback current readback
// --------------------------------------------------
`timescale 1ns/1ps
`include "qla_params.svh"

module dac_cmd_regs (
    input  logic                                       sysclk,
    input  logic                                       reset,
    reg_bus_if.responder                               bus,
    input  qla_axis_pkg::current_t [`QLA_NUM_AXES-1:0] cur_fb,   // sampled feedback
    output qla_reg_pkg::reg_data_t                     rdata,
    output qla_axis_pkg::current_t [`QLA_NUM_AXES-1:0] cur_cmd   // index 0 is axis 1
);

    import qla_reg_pkg::*;

    logic wr_dac;    // dac write in main space, any channel

    assign wr_dac = bus.wen && (bus.waddr[15:12] == SPACE_MAIN)
                  && (bus.waddr[3:0] == OFF_DAC_CTRL);

    // channel k loads axis k
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd <= '0;
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (wr_dac && (bus.waddr[7:4] == 4'(i + 1)))
                    cur_cmd[i] <= bus.wdata[15:0];
            end
        end
    end

    // --------------------------------------------------
    // readback, zero for channels without an axis
    // --------------------------------------------------
    always_comb begin
        rdata = '0;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            if (bus.raddr[7:4] == 4'(i + 1)) begin
                case (bus.raddr[3:0])
                    OFF_DAC_CTRL: rdata = {16'h0000, cur_cmd[i]};
                    OFF_ADC_DATA: rdata = {16'h0000, cur_fb[i]};
                    default:      rdata = '0;
                endcase
            end
        end
    end

endmodule

// ==== src/board_regs.sv ====
// --------------------------------------------------
// channel 0 board registers: power, amp enables,
// digital outputs and safety status
// --------------------------------------------------
`timescale 1ns/1ps
`include "qla_params.svh"

module board_regs (
    input  logic                         sysclk,
    input  logic                         reset,
    reg_bus_if.responder                 bus,
    input  logic [`QLA_BOARD_ID_W-1:0]   board_id,
    input  logic                         dout_bidir,       // invert dout when set
    input  qla_axis_pkg::axis_mask_t     safety_disable,
    output qla_reg_pkg::reg_data_t       rdata,
    output qla_axis_pkg::axis_mask_t     clear_disable,    // 1-cycle pulse per axis
    output logic                         pwr_enable,
    output qla_axis_pkg::axis_mask_t     amp_enable,
    output logic [3:0]                   dout_pins
);

    import qla_reg_pkg::*;
    import qla_axis_pkg::*;

    axis_mask_t  amp_req;          // host enable request
    logic [3:0]  dout;             // dout register, before inversion
    logic        wr_chan0;         // write hits main space, channel 0
    logic        wr_status;
    logic        wr_dout;
    reg_data_t   status_word;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------
    assign wr_chan0  = bus.wen && (bus.waddr[15:12] == SPACE_MAIN)
                     && (bus.waddr[7:4] == 4'd0);
    assign wr_status = wr_chan0 && (bus.waddr[3:0] == OFF_STATUS);
    assign wr_dout   = wr_chan0 && (bus.waddr[3:0] == OFF_DOUT_CTRL);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable    <= 1'b0;
            amp_req       <= '0;
            dout          <= 4'h0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;                          // default, no clear
            if (wr_status) begin
                pwr_enable <= bus.wdata[19];
                amp_req    <= bus.wdata[`QLA_NUM_AXES-1:0];
                // enabling an axis re-arms its safety latch
                if (bus.wdata[19])
                    clear_disable <= '1;                  // power on clears all
                else
                    clear_disable <= bus.wdata[`QLA_NUM_AXES-1:0];
            end
            if (wr_dout)
                dout <= bus.wdata[3:0];
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    // request gated by power and by tripped axes
    assign amp_enable = amp_req & {`QLA_NUM_AXES{pwr_enable}} & ~safety_disable;

    // bidir config inverts every pin
    assign dout_pins = dout ^ {4{dout_bidir}};

    // status layout
    assign status_word = {4'h0,              // 31:28
                          board_id,          // 27:24
                          4'h0,              // 23:20
                          pwr_enable,        // 19
                          dout_bidir,        // 18
                          6'h00,             // 17:12
                          safety_disable,    // 11:8
                          4'h0,              // 7:4
                          amp_req};          // 3:0

    // read word, top already picked channel 0
    always_comb begin
        case (bus.raddr[3:0])
            OFF_STATUS:    rdata = status_word;
            OFF_DOUT_CTRL: rdata = {28'h0, dout};
            default:       rdata = '0;
        endcase
    end

endmodule

// ==== src/reg_bus_if.sv ====
// --------------------------------------------------
// host register bus: write port plus read address
// --------------------------------------------------
`timescale 1ns/1ps

interface reg_bus_if;

    qla_reg_pkg::reg_addr_t waddr;    // write address
    qla_reg_pkg::reg_data_t wdata;    // write data
    logic                   wen;      // one write per edge while high
    qla_reg_pkg::reg_addr_t raddr;    // read address, data comes back per block

    // host side drives everything
    modport host (
        output waddr, wdata, wen, raddr
    );

    // register blocks decode their own channel/offset
    modport responder (
        input waddr, wdata, wen, raddr
    );

endinterface

// ==== src/qla_axis_pkg.sv ====
// --------------------------------------------------
// per-axis types: current words, axis masks, safety
// --------------------------------------------------
`include "qla_params.svh"

package qla_axis_pkg;

    typedef logic [15:0] current_t;                   // offset binary
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;    // bit 0 is axis 1

    // per-axis overcurrent state
    typedef enum logic [1:0] {
        SAFE_ARMED    = 2'd0,
        SAFE_COUNTING = 2'd1,
        SAFE_TRIPPED  = 2'd2
    } safe_state_e;

endpackage

// ==== src/qla_reg_pkg.sv ====
// --------------------------------------------------
// register map types: address spaces, offsets and
// the host bus word types
// --------------------------------------------------
package qla_reg_pkg;

    typedef logic [15:0] reg_addr_t;    // one-word register address
    typedef logic [31:0] reg_data_t;    // one-word register data

    // address bits 15:12
    typedef enum logic [3:0] {
        SPACE_MAIN     = 4'h0,          // board + axis registers
        SPACE_HUB      = 4'h1,          // unmapped, reads zero
        SPACE_PROM     = 4'h2,          // unmapped, reads zero
        SPACE_PROM_QLA = 4'h3,          // unmapped, reads zero
        SPACE_DS       = 4'h4           // unmapped, reads zero
    } addr_space_e;

    // address bits 3:0, within a channel (bits 7:4)
    typedef enum logic [3:0] {
        OFF_STATUS    = 4'h0,           // channel 0 only
        OFF_ADC_DATA  = 4'h1,           // channels 1..4
        OFF_DAC_CTRL  = 4'h2,           // channels 1..4
        OFF_DOUT_CTRL = 4'h6            // channel 0
    } reg_offset_e;

endpackage

// ==== src/qla_params.svh ====
// --------------------------------------------------
// motor-axis core constants: axis count, current
// scaling and safety trip thresholds
// --------------------------------------------------
`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// number of motor axes on the board
`define QLA_NUM_AXES          4

// offset-binary zero current
`define QLA_CUR_MIDSCALE      16'h8000

// excess over twice the command before a cycle counts
`define QLA_SAFETY_MARGIN     16'h0100

// consecutive over-limit cycles that latch a trip
`define QLA_SAFETY_TRIP_COUNT 8

// rotary switch width
`define QLA_BOARD_ID_W        4

`endif
